//--- design/id_pkg.sv
////////////////////////////////////////////////////////////
// RISC-V decode definitions shared by the decode stage
// Opcode codes are instruction bits 6:2 only
// Only the opcodes this stage classifies are listed
////////////////////////////////////////////////////////////

package id_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  opcode_t;

  ////////////////////////////////////////////////////////////
  // Instruction field positions
  ////////////////////////////////////////////////////////////
  localparam int opc_lo    = 2;
  localparam int opc_hi    = 6;
  localparam int rd_lo     = 7;
  localparam int rd_hi     = 11;
  localparam int funct3_lo = 12;
  localparam int funct3_hi = 14;
  localparam int rs1_lo    = 15;
  localparam int rs1_hi    = 19;
  localparam int rs2_lo    = 20;
  localparam int rs2_hi    = 24;
  localparam int funct7_lo = 25;
  localparam int funct7_hi = 31;
  localparam int uimm_lo   = 12;
  localparam int uimm_hi   = 31;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////
  localparam opcode_t opc_load     = 5'b00000;
  localparam opcode_t opc_misc_mem = 5'b00011;
  localparam opcode_t opc_op_imm   = 5'b00100;
  localparam opcode_t opc_auipc    = 5'b00101;
  localparam opcode_t opc_op_imm32 = 5'b00110;
  localparam opcode_t opc_store    = 5'b01000;
  localparam opcode_t opc_op       = 5'b01100;
  localparam opcode_t opc_lui      = 5'b01101;
  localparam opcode_t opc_op32     = 5'b01110;
  localparam opcode_t opc_branch   = 5'b11000;
  localparam opcode_t opc_jalr     = 5'b11001;
  localparam opcode_t opc_jal      = 5'b11011;
  localparam opcode_t opc_system   = 5'b11100;

  // Opcodes that leave a result in rd
  function automatic logic opcode_writes_rd(opcode_t opc);
    case (opc)
      opc_load, opc_op_imm, opc_auipc, opc_op_imm32, opc_op,
      opc_lui, opc_op32, opc_jalr, opc_jal, opc_system: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic opcode_reads_rs1(opcode_t opc);
    case (opc)
      opc_op_imm, opc_op_imm32, opc_op, opc_op32, opc_branch,
      opc_jalr, opc_load, opc_store, opc_system: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic opcode_reads_rs2(opcode_t opc);
    case (opc)
      opc_op, opc_op32, opc_branch, opc_store: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

//--- design/operand_route.sv
////////////////////////////////////////////////////////////
// Operand selection and forwarding flags, purely combinational
// Unknown opcodes give zero operands and no forwarding
// Flags of zero mean the register file value is used
////////////////////////////////////////////////////////////

module operand_route #(
  parameter int xlen = 32
) (
  input  id_pkg::instr_t  instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  id_pkg::instr_t  ex_instr,
  input  logic            ex_bubble,
  input  id_pkg::instr_t  wb_instr,
  input  logic            wb_bubble,
  output logic [xlen-1:0] op_a,
  output logic [xlen-1:0] op_b,
  output logic            byp_ex_a,
  output logic            byp_ex_b,
  output logic            byp_wb_a,
  output logic            byp_wb_b
);

  id_pkg::opcode_t   opc;
  id_pkg::opcode_t   ex_opc;
  id_pkg::opcode_t   wb_opc;
  id_pkg::reg_addr_t rs1;
  id_pkg::reg_addr_t rs2;
  id_pkg::reg_addr_t ex_rd;
  id_pkg::reg_addr_t wb_rd;

  logic signed [11:0] imm_i12;
  logic signed [31:0] imm_u32;
  logic [xlen-1:0]    imm_i;
  logic [xlen-1:0]    imm_u;

  logic reads_rs1;
  logic reads_rs2;
  logic ex_hit;
  logic wb_hit;

  assign opc    = instr[id_pkg::opc_hi:id_pkg::opc_lo];
  assign ex_opc = ex_instr[id_pkg::opc_hi:id_pkg::opc_lo];
  assign wb_opc = wb_instr[id_pkg::opc_hi:id_pkg::opc_lo];
  assign rs1    = instr[id_pkg::rs1_hi:id_pkg::rs1_lo];
  assign rs2    = instr[id_pkg::rs2_hi:id_pkg::rs2_lo];
  assign ex_rd  = ex_instr[id_pkg::rd_hi:id_pkg::rd_lo];
  assign wb_rd  = wb_instr[id_pkg::rd_hi:id_pkg::rd_lo];

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////
  // I immediate sits in funct7 and rs2 fields
  assign imm_i12 = instr[id_pkg::funct7_hi:id_pkg::rs2_lo];
  assign imm_u32 = {instr[id_pkg::uimm_hi:id_pkg::uimm_lo], 12'b0};

  // Signed casts extend the sign bit up to xlen
  assign imm_i = xlen'(imm_i12);
  assign imm_u = xlen'(imm_u32);

  ////////////////////////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (opc)
      id_pkg::opc_op_imm, id_pkg::opc_op_imm32, id_pkg::opc_load, id_pkg::opc_jalr: begin
        op_a = rs1_data;
        op_b = imm_i;
      end
      id_pkg::opc_auipc: begin
        op_a = pc;
        op_b = imm_u;
      end
      id_pkg::opc_lui: begin
        op_a = '0;
        op_b = imm_u;
      end
      id_pkg::opc_op, id_pkg::opc_op32, id_pkg::opc_branch, id_pkg::opc_store: begin
        op_a = rs1_data;
        op_b = rs2_data;
      end
      id_pkg::opc_system: begin
        // CSR immediate forms take the rs1 field as data
        op_a = rs1_data;
        op_b = xlen'(rs1);
      end
      default: begin
        op_a = '0;
        op_b = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////
  assign reads_rs1 = id_pkg::opcode_reads_rs1(opc);
  assign reads_rs2 = id_pkg::opcode_reads_rs2(opc);

  // x0 may carry junk in flight so rd of zero never forwards
  assign ex_hit = !ex_bubble && (ex_rd != '0) && id_pkg::opcode_writes_rd(ex_opc);
  assign wb_hit = !wb_bubble && (wb_rd != '0) && id_pkg::opcode_writes_rd(wb_opc);

  assign byp_ex_a = reads_rs1 && ex_hit && (rs1 == ex_rd);
  assign byp_ex_b = reads_rs2 && ex_hit && (rs2 == ex_rd);
  assign byp_wb_a = reads_rs1 && wb_hit && (rs1 == wb_rd);
  assign byp_wb_b = reads_rs2 && wb_hit && (rs2 == wb_rd);

endmodule

//--- design/instr_legality.sv
////////////////////////////////////////////////////////////
// Illegal instruction check for RV32I/RV64I and M
// Every CSR access and every xRET is reported illegal
// Compressed encodings are not supported
////////////////////////////////////////////////////////////

module instr_legality #(
  parameter int xlen       = 32,
  parameter int has_muldiv = 1
) (
  input  id_pkg::instr_t instr,
  output logic           illegal
);

  localparam bit is_rv64   = (xlen == 64);
  localparam bit muldiv_en = (has_muldiv != 0);

  localparam id_pkg::instr_t ecall  = 32'h0000_0073;
  localparam id_pkg::instr_t ebreak = 32'h0010_0073;

  id_pkg::opcode_t opc;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            legal;

  assign opc    = instr[id_pkg::opc_hi:id_pkg::opc_lo];
  assign funct3 = instr[id_pkg::funct3_hi:id_pkg::funct3_lo];
  assign funct7 = instr[id_pkg::funct7_hi:id_pkg::funct7_lo];

  always_comb begin
    case (opc)
      id_pkg::opc_lui, id_pkg::opc_auipc, id_pkg::opc_jal: legal = 1'b1;
      id_pkg::opc_jalr:     legal = (funct3 == 3'b000);
      id_pkg::opc_branch:   legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      id_pkg::opc_misc_mem: legal = (funct3 == 3'b000) || (funct3 == 3'b001);
      id_pkg::opc_system:   legal = (instr == ecall) || (instr == ebreak);
      id_pkg::opc_op_imm: begin
        // Shift amount bit 5 lives in funct7 bit 0
        case (funct3)
          3'b001:  legal = (funct7[6:1] == 6'b000000) && (is_rv64 || !funct7[0]);
          3'b101:  legal = ((funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000)) &&
                           (is_rv64 || !funct7[0]);
          default: legal = 1'b1;
        endcase
      end
      id_pkg::opc_op: begin
        case (funct7)
          7'b0000000: legal = 1'b1;
          7'b0100000: legal = (funct3 == 3'b000) || (funct3 == 3'b101);
          7'b0000001: legal = muldiv_en;
          default:    legal = 1'b0;
        endcase
      end
      id_pkg::opc_op_imm32: begin
        case (funct3)
          3'b000:  legal = is_rv64;
          3'b001:  legal = is_rv64 && (funct7 == 7'b0000000);
          3'b101:  legal = is_rv64 && ((funct7 == 7'b0000000) || (funct7 == 7'b0100000));
          default: legal = 1'b0;
        endcase
      end
      id_pkg::opc_op32: begin
        // MULW, DIVW, DIVUW, REMW and REMUW
        case (funct7)
          7'b0000000: legal = is_rv64 && (funct3 == 3'b000 || funct3 == 3'b001 ||
                                          funct3 == 3'b101);
          7'b0100000: legal = is_rv64 && (funct3 == 3'b000 || funct3 == 3'b101);
          7'b0000001: legal = is_rv64 && muldiv_en && (funct3 == 3'b000 || funct3[2]);
          default:    legal = 1'b0;
        endcase
      end
      id_pkg::opc_load: begin
        case (funct3)
          3'b000, 3'b001, 3'b010, 3'b100, 3'b101: legal = 1'b1;
          3'b011, 3'b110: legal = is_rv64;
          default:        legal = 1'b0;
        endcase
      end
      id_pkg::opc_store: legal = (funct3 <= 3'b010) || (is_rv64 && funct3 == 3'b011);
      default:           legal = 1'b0;
    endcase
  end

  // Low opcode bits must be 11 without the C extension
  assign illegal = !legal || (instr[1:0] != 2'b11);

endmodule

//--- design/decode_handshake.sv
////////////////////////////////////////////////////////////
// Four-phase req/ack on both sides, one item in flight
// Capture needs both sides idle, outputs hold until release
////////////////////////////////////////////////////////////

module decode_handshake #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_req,
  input  logic            out_ack,
  input  logic [xlen-1:0] route_op_a,
  input  logic [xlen-1:0] route_op_b,
  input  logic            route_byp_ex_a,
  input  logic            route_byp_ex_b,
  input  logic            route_byp_wb_a,
  input  logic            route_byp_wb_b,
  input  logic            route_illegal,
  output logic            in_ack,
  output logic            out_req,
  output logic [xlen-1:0] op_a,
  output logic [xlen-1:0] op_b,
  output logic            byp_ex_a,
  output logic            byp_ex_b,
  output logic            byp_wb_a,
  output logic            byp_wb_b,
  output logic            illegal
);

  logic capture;

  // Both handshakes must be back at rest before a new item
  assign capture = in_req && !in_ack && !out_req && !out_ack;

  ////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else begin
      if (capture) begin
        in_ack <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end

      if (capture) begin
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_a     <= '0;
      op_b     <= '0;
      byp_ex_a <= 1'b0;
      byp_ex_b <= 1'b0;
      byp_wb_a <= 1'b0;
      byp_wb_b <= 1'b0;
      illegal  <= 1'b0;
    end else if (capture) begin
      op_a     <= route_op_a;
      op_b     <= route_op_b;
      byp_ex_a <= route_byp_ex_a;
      byp_ex_b <= route_byp_ex_b;
      byp_wb_a <= route_byp_wb_a;
      byp_wb_b <= route_byp_wb_b;
      illegal  <= route_illegal;
    end
  end

endmodule

//--- design/id_stage_top.sv
////////////////////////////////////////////////////////////
// Decode stage operand side, xlen is 32 or 64
// Inputs must stay stable while in_req is high
////////////////////////////////////////////////////////////

module id_stage_top #(
  parameter int xlen       = 32,
  parameter int has_muldiv = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_req,
  input  id_pkg::instr_t  instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  id_pkg::instr_t  ex_instr,
  input  logic            ex_bubble,
  input  id_pkg::instr_t  wb_instr,
  input  logic            wb_bubble,
  input  logic            out_ack,
  output logic            in_ack,
  output logic            out_req,
  output logic [xlen-1:0] op_a,
  output logic [xlen-1:0] op_b,
  output logic            byp_ex_a,
  output logic            byp_ex_b,
  output logic            byp_wb_a,
  output logic            byp_wb_b,
  output logic            illegal
);

  logic [xlen-1:0] route_op_a;
  logic [xlen-1:0] route_op_b;
  logic            route_byp_ex_a;
  logic            route_byp_ex_b;
  logic            route_byp_wb_a;
  logic            route_byp_wb_b;
  logic            route_illegal;

  // Router and checker both look at the incoming instruction
  operand_route #(
    .xlen(xlen)
  ) i_operand_route (
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex_instr (ex_instr),
    .ex_bubble(ex_bubble),
    .wb_instr (wb_instr),
    .wb_bubble(wb_bubble),
    .op_a     (route_op_a),
    .op_b     (route_op_b),
    .byp_ex_a (route_byp_ex_a),
    .byp_ex_b (route_byp_ex_b),
    .byp_wb_a (route_byp_wb_a),
    .byp_wb_b (route_byp_wb_b)
  );

  instr_legality #(
    .xlen      (xlen),
    .has_muldiv(has_muldiv)
  ) i_instr_legality (
    .instr  (instr),
    .illegal(route_illegal)
  );

  decode_handshake #(
    .xlen(xlen)
  ) i_decode_handshake (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_req        (in_req),
    .out_ack       (out_ack),
    .route_op_a    (route_op_a),
    .route_op_b    (route_op_b),
    .route_byp_ex_a(route_byp_ex_a),
    .route_byp_ex_b(route_byp_ex_b),
    .route_byp_wb_a(route_byp_wb_a),
    .route_byp_wb_b(route_byp_wb_b),
    .route_illegal (route_illegal),
    .in_ack        (in_ack),
    .out_req       (out_req),
    .op_a          (op_a),
    .op_b          (op_b),
    .byp_ex_a      (byp_ex_a),
    .byp_ex_b      (byp_ex_b),
    .byp_wb_a      (byp_wb_a),
    .byp_wb_b      (byp_wb_b),
    .illegal       (illegal)
  );

endmodule

//--- dv/id_stage_asserts.sv
////////////////////////////////////////////////////////////
// Handshake properties for decode_handshake
// Assumes the synchronous active low reset of the stage
////////////////////////////////////////////////////////////

module id_stage_asserts #(
  parameter int xlen = 32
) (
  input logic            clk,
  input logic            rst_n,
  input logic            in_req,
  input logic            in_ack,
  input logic            out_req,
  input logic            out_ack,
  input logic [xlen-1:0] op_a,
  input logic [xlen-1:0] op_b,
  input logic            byp_ex_a,
  input logic            byp_ex_b,
  input logic            byp_wb_a,
  input logic            byp_wb_b,
  input logic            illegal
);

  // Failed property count, read by the testbench at the end
  int failures = 0;

  // in_ack drops only once the producer has let go
  ack_release_check: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(in_ack) |-> !$past(in_req)
  ) else begin
    failures++;
    $error("in_ack fell while in_req was still high");
  end

  req_hold_check: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(out_req) |-> $past(out_ack)
  ) else begin
    failures++;
    $error("out_req fell before out_ack was seen");
  end

  // No capture between two cycles with out_req high
  data_stable_check: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_req && $past(out_req) |-> $stable(op_a) && $stable(op_b) &&
      $stable({byp_ex_a, byp_ex_b, byp_wb_a, byp_wb_b}) && $stable(illegal)
  ) else begin
    failures++;
    $error("outputs changed while out_req was high");
  end

  reset_exit_check: assert property (
    @(posedge clk) $rose(rst_n) |-> !in_ack && !out_req
  ) else begin
    failures++;
    $error("handshake not idle after reset");
  end

endmodule

bind decode_handshake id_stage_asserts #(
  .xlen(xlen)
) i_id_stage_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .in_req  (in_req),
  .in_ack  (in_ack),
  .out_req (out_req),
  .out_ack (out_ack),
  .op_a    (op_a),
  .op_b    (op_b),
  .byp_ex_a(byp_ex_a),
  .byp_ex_b(byp_ex_b),
  .byp_wb_a(byp_wb_a),
  .byp_wb_b(byp_wb_b),
  .illegal (illegal)
);

//--- dv/tb_id_stage.sv
////////////////////////////////////////////////////////////
// Testbench for id_stage_top with xlen 32 and mul/div on
// Vectors are 12 hex words each, read from dv/id_vectors.txt
// Flag word packs ex_a, ex_b, wb_a, wb_b from msb down
////////////////////////////////////////////////////////////

module tb_id_stage;

  localparam int xlen             = 32;
  localparam int num_vectors      = 32;
  localparam int words_per_vector = 12;
  localparam int max_wait         = 40;
  localparam int drive_delay      = 10;

  logic            clk;
  logic            rst_n;
  logic            in_req;
  id_pkg::instr_t  instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  id_pkg::instr_t  ex_instr;
  logic            ex_bubble;
  id_pkg::instr_t  wb_instr;
  logic            wb_bubble;
  logic            out_ack;
  logic            in_ack;
  logic            out_req;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic            byp_ex_a;
  logic            byp_ex_b;
  logic            byp_wb_a;
  logic            byp_wb_b;
  logic            illegal;

  logic [31:0] vec_mem [0:num_vectors*words_per_vector-1];

  int   errors;
  int   timeouts;
  int   other_errors;
  int   assert_failures;
  int   captures;
  int   received;
  int   seed;
  logic prev_in_ack;
  logic prev_out_req;

  id_stage_top #(
    .xlen      (xlen),
    .has_muldiv(1)
  ) i_id_stage_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex_instr (ex_instr),
    .ex_bubble(ex_bubble),
    .wb_instr (wb_instr),
    .wb_bubble(wb_bubble),
    .out_ack  (out_ack),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .op_a     (op_a),
    .op_b     (op_b),
    .byp_ex_a (byp_ex_a),
    .byp_ex_b (byp_ex_b),
    .byp_wb_a (byp_wb_a),
    .byp_wb_b (byp_wb_b),
    .illegal  (illegal)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // All driving and sampling happens just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  // Outputs keep the vector's expected values until out_req drops
  task automatic check_held(input string tag, input int base);
    check_value({tag, " held op_a"}, vec_mem[base+8], op_a);
    check_value({tag, " held op_b"}, vec_mem[base+9], op_b);
    check_value({tag, " held flags"}, vec_mem[base+10],
                {byp_ex_a, byp_ex_b, byp_wb_a, byp_wb_b});
    check_value({tag, " held illegal"}, vec_mem[base+11], illegal);
  endtask

  ////////////////////////////////////////////////////////////
  // Producer side
  ////////////////////////////////////////////////////////////
  task automatic send_vector(input int idx);
    int base;
    int waited;
    base      = idx * words_per_vector;
    instr     = vec_mem[base];
    pc        = vec_mem[base+1];
    rs1_data  = vec_mem[base+2];
    rs2_data  = vec_mem[base+3];
    ex_instr  = vec_mem[base+4];
    ex_bubble = vec_mem[base+5][0];
    wb_instr  = vec_mem[base+6];
    wb_bubble = vec_mem[base+7][0];
    in_req    = 1'b1;
    waited    = 0;
    while (!in_ack && waited < max_wait) begin
      next_cycle();
      waited++;
    end
    if (!in_ack) begin
      timeouts++;
      $display("Input handshake stalled: in_ack never rose for vector %0d", idx);
    end else if (idx == 0) begin
      // Idle output side, so capture takes one cycle
      check_value("vector 0 capture latency", 1, waited);
      check_value("vector 0 out_req with in_ack", 1, out_req);
    end
    in_req = 1'b0;
    waited = 0;
    while (in_ack && waited < max_wait) begin
      next_cycle();
      waited++;
    end
    if (in_ack) begin
      timeouts++;
      $display("Input handshake stalled: in_ack never fell for vector %0d", idx);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Consumer side
  ////////////////////////////////////////////////////////////
  task automatic receive_vector(input int idx);
    int    base;
    int    waited;
    int    delay;
    string tag;
    base   = idx * words_per_vector;
    tag    = $sformatf("vector %0d", idx);
    waited = 0;
    while (!out_req && waited < max_wait) begin
      next_cycle();
      waited++;
    end
    if (!out_req) begin
      timeouts++;
      $display("Output handshake stalled: out_req never rose for vector %0d", idx);
    end else begin
      received++;
      check_value({tag, " op_a"}, vec_mem[base+8], op_a);
      check_value({tag, " op_b"}, vec_mem[base+9], op_b);
      check_value({tag, " flags"}, vec_mem[base+10],
                  {byp_ex_a, byp_ex_b, byp_wb_a, byp_wb_b});
      check_value({tag, " illegal"}, vec_mem[base+11], illegal);
      // Random back-pressure before the ack
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) begin
        next_cycle();
        check_held(tag, base);
      end
      out_ack = 1'b1;
      waited  = 0;
      while (out_req && waited < max_wait) begin
        next_cycle();
        waited++;
        check_held(tag, base);
      end
      if (out_req) begin
        timeouts++;
        $display("Output handshake stalled: out_req never fell for vector %0d", idx);
      end
      out_ack = 1'b0;
    end
  endtask

  // Count captures and catch an ack while the output is busy
  always @(negedge clk) begin
    if (rst_n && in_ack && !prev_in_ack) begin
      captures++;
      if (prev_out_req) begin
        other_errors++;
        $display("A new item was acknowledged while the output side was still busy");
      end
    end
    prev_in_ack  = in_ack;
    prev_out_req = out_req;
  end

  initial begin
    int i;
    clk             = 1'b0;
    rst_n           = 1'b0;
    in_req          = 1'b0;
    instr           = '0;
    pc              = '0;
    rs1_data        = '0;
    rs2_data        = '0;
    ex_instr        = '0;
    ex_bubble       = 1'b0;
    wb_instr        = '0;
    wb_bubble       = 1'b0;
    out_ack         = 1'b0;
    errors          = 0;
    timeouts        = 0;
    other_errors    = 0;
    assert_failures = 0;
    captures        = 0;
    received        = 0;
    prev_in_ack     = 1'b0;
    prev_out_req    = 1'b0;
    seed            = 32'h8b04_5baa;
    $readmemh("dv/id_vectors.txt", vec_mem);
    for (i = 0; i < num_vectors * words_per_vector; i++) begin
      if ($isunknown(vec_mem[i])) begin
        other_errors++;
        $display("Vector file is short or unreadable at word %0d", i);
        break;
      end
    end

    repeat (2) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    check_value("reset in_ack", 0, in_ack);
    check_value("reset out_req", 0, out_req);
    check_value("reset op_a", 0, op_a);
    check_value("reset op_b", 0, op_b);
    check_value("reset flags", 0, {byp_ex_a, byp_ex_b, byp_wb_a, byp_wb_b});
    check_value("reset illegal", 0, illegal);

    fork
      for (int v = 0; v < num_vectors; v++) begin
        send_vector(v);
      end
      for (int v = 0; v < num_vectors; v++) begin
        receive_vector(v);
      end
    join

    next_cycle();
    check_value("items received", num_vectors, received);
    check_value("items captured", num_vectors, captures);
    assert_failures = i_id_stage_top.i_decode_handshake.i_id_stage_asserts.failures;
    $display("Summary: %0d check failures, %0d timeouts, %0d assertion failures, %0d other errors",
             errors, timeouts, assert_failures, other_errors);
    if (errors == 0 && timeouts == 0 && assert_failures == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- dv/id_vectors.txt
// instr pc rs1_data rs2_data ex_instr ex_bubble wb_instr wb_bubble
// then expected op_a op_b flags (ex_a ex_b wb_a wb_b) illegal, all hex
FFF10093 00001000 11111111 22222222 00000013 0 00000013 0 11111111 FFFFFFFF 0 0
7FF30293 00001000 11111111 22222222 00000013 0 00000013 0 11111111 000007FF 0 0
80000197 00001000 11111111 22222222 00000013 0 00000013 0 00001000 80000000 0 0
12345237 00001000 11111111 22222222 00000013 0 00000013 0 00000000 12345000 0 0
003100B3 00001000 A5A5A5A5 5A5A5A5A 00000013 0 00000013 0 A5A5A5A5 5A5A5A5A 0 0
00312423 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 0
00310463 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 0
00000073 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000000 0 0
00100073 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000000 0 0
0010800B 00001000 11111111 22222222 00100093 0 00000013 0 00000000 00000000 0 1
0FF0000F 00001000 11111111 22222222 00000013 0 00000013 0 00000000 00000000 0 0
300110F3 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000002 0 1
02011093 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000020 0 1
00511093 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000005 0 0
40315093 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000403 0 0
0011009B 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000001 0 1
003100BB 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 1
00013083 00001000 11111111 22222222 00000013 0 00000013 0 11111111 00000000 0 1
FFC12083 00001000 11111111 22222222 00000013 0 00000013 0 11111111 FFFFFFFC 0 0
023100B3 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 0
023150B3 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 0
00313023 00001000 11111111 22222222 00000013 0 00000013 0 11111111 22222222 0 1
003100B3 00001000 11111111 22222222 00000113 0 00000193 0 11111111 22222222 9 0
003100B3 00001000 11111111 22222222 00000193 0 00000113 0 11111111 22222222 6 0
003100B3 00001000 11111111 22222222 00000113 0 00000113 0 11111111 22222222 A 0
003100B3 00001000 11111111 22222222 00000113 1 00000193 1 11111111 22222222 0 0
003000B3 00001000 11111111 22222222 00000013 0 00000193 0 11111111 22222222 1 0
003100B3 00001000 11111111 22222222 00002123 0 000001E3 0 11111111 22222222 0 0
00310093 00001000 11111111 22222222 00000113 0 00000193 0 11111111 00000003 8 0
00312423 00001000 11111111 22222222 00000193 0 00000113 0 11111111 22222222 6 0
000100E7 00001000 11111111 22222222 00002103 0 00000013 0 11111111 00000000 8 0
00310463 00001000 11111111 22222222 000001EF 0 00000137 0 11111111 22222222 6 0

//--- list.f
design/id_pkg.sv
design/operand_route.sv
design/instr_legality.sv
design/decode_handshake.sv
design/id_stage_top.sv
dv/id_stage_asserts.sv
dv/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - design/id_pkg.sv
  - design/operand_route.sv
  - design/instr_legality.sv
  - design/decode_handshake.sv
  - design/id_stage_top.sv
  - target: test
    files:
      - dv/id_stage_asserts.sv
      - dv/tb_id_stage.sv
